//--- hw/fetch_pkg.sv
package fetch_pkg;

    // next-PC source, in falling priority
    typedef enum logic [2:0] {
        src_eret    = 3'd0,
        src_exc     = 3'd1,
        src_refetch = 3'd2,
        src_correct = 3'd3,
        src_predict = 3'd4,
        src_seq     = 3'd5
    } pc_src_t;

    // redirect requests from later stages and the predictor
    typedef struct packed {
        logic        eret_valid;
        logic        exc_valid;
        logic        refetch_valid;
        logic        correct_valid;
        logic        predict_valid;
        logic [31:0] eret_pc;       // epc from cp0
        logic [31:0] exc_vector;
        logic [31:0] refetch_pc;
        logic [31:0] correct_pc;    // branch correction from ex
        logic [31:0] predict_pc;
    } redirect_t;

    typedef enum logic [1:0] {
        exc_none        = 2'd0,
        exc_tlb_refill  = 2'd1,
        exc_tlb_invalid = 2'd2,
        exc_addr_error  = 2'd3
    } fetch_exc_t;

    // instruction cache request
    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        cached;
    } fetch_req_t;

endpackage

//--- hw/mmu_pkg.sv
package mmu_pkg;

    // one page pair as handed back by the main TLB
    typedef struct packed {
        logic [18:0] vpn2;   // va[31:13]
        logic [19:0] pfn0;   // even page
        logic        c0;
        logic        v0;
        logic [19:0] pfn1;   // odd page
        logic        c1;
        logic        v1;
    } page_entry_t;

    // result of the instruction side translation
    typedef struct packed {
        logic                  ready;   // paddr / exc are meaningful
        logic [31:0]           paddr;
        logic                  cached;
        fetch_pkg::fetch_exc_t exc;     // refill, invalid or none
    } xlate_t;

    // unmapped segments, only the top three bits matter
    localparam logic [31:0] kseg0_base = 32'h8000_0000;
    localparam logic [31:0] kseg1_base = 32'ha000_0000;

endpackage

//--- hw/redirect_arbiter.sv
`timescale 1ns/1ps

module redirect_arbiter (
    input  fetch_pkg::redirect_t redirect,
    output fetch_pkg::pc_src_t   pc_src
);

    // oldest instruction in the pipe wins, so eret and exceptions come first
    logic [4:0] flags;

    assign flags = {
        redirect.eret_valid,
        redirect.exc_valid,
        redirect.refetch_valid,
        redirect.correct_valid,
        redirect.predict_valid
    };

    always_comb begin
        unique casez (flags)
            5'b1????: begin
                pc_src = fetch_pkg::src_eret;
            end
            5'b01???: begin
                pc_src = fetch_pkg::src_exc;
            end
            5'b001??: begin
                pc_src = fetch_pkg::src_refetch;   // e.g. after a cache op
            end
            5'b0001?: begin
                pc_src = fetch_pkg::src_correct;   // mispredict fixed in ex
            end
            5'b00001: begin
                pc_src = fetch_pkg::src_predict;
            end
            default: begin
                pc_src = fetch_pkg::src_seq;       // nothing pending
            end
        endcase
    end

endmodule

//--- hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pc_write,
    input  fetch_pkg::pc_src_t   pc_src,
    input  fetch_pkg::redirect_t redirect,
    output logic [31:0]          pc
);

    logic [31:0] pc_plus4;
    logic [31:0] next_pc;

    assign pc_plus4 = pc + 32'd4;

    // six way next-pc mux
    always_comb begin
        case (pc_src)
            fetch_pkg::src_eret:    next_pc = redirect.eret_pc;
            fetch_pkg::src_exc:     next_pc = redirect.exc_vector;
            fetch_pkg::src_refetch: next_pc = redirect.refetch_pc;
            fetch_pkg::src_correct: next_pc = redirect.correct_pc;
            fetch_pkg::src_predict: next_pc = redirect.predict_pc;
            default:                next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (pc_write) begin
            pc <= next_pc;   // otherwise hold for the stalled stage
        end
    end

endmodule

//--- hw/itlb_buffer.sv
`timescale 1ns/1ps

module itlb_buffer #(
    parameter int itlb_entries = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          vaddr,
    input  logic                 flush,
    input  logic                 fill_valid,
    input  logic                 fill_found,
    input  mmu_pkg::page_entry_t fill_entry,
    output mmu_pkg::xlate_t      xlate,
    output logic                 tlb_stall,
    output logic [18:0]          miss_vpn2
);

    localparam int idx_w = (itlb_entries > 1) ? $clog2(itlb_entries) : 1;

    mmu_pkg::page_entry_t    entry_q [itlb_entries];
    logic [itlb_entries-1:0] valid_q;
    logic [itlb_entries-1:0] found_q;    // low means a cached refill answer
    logic [idx_w-1:0]        victim_q;   // round-robin pointer
    logic [idx_w-1:0]        next_victim;

    logic                    in_kseg0;
    logic                    in_kseg1;
    logic                    unmapped;
    logic [itlb_entries-1:0] hit_vec;
    logic                    hit;
    mmu_pkg::page_entry_t    hit_entry;
    logic                    hit_found;
    logic                    odd_page;
    logic [19:0]             sel_pfn;
    logic                    sel_c;
    logic                    sel_v;

    assign in_kseg0 = (vaddr[31:29] == mmu_pkg::kseg0_base[31:29]);
    assign in_kseg1 = (vaddr[31:29] == mmu_pkg::kseg1_base[31:29]);
    assign unmapped = in_kseg0 || in_kseg1;

    assign next_victim = (victim_q == idx_w'(itlb_entries - 1)) ? '0 : victim_q + 1'b1;

    // control state, flush beats a fill in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[victim_q] <= 1'b1;
            victim_q          <= next_victim;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid && !flush) begin
            entry_q[victim_q] <= fill_entry;
            found_q[victim_q] <= fill_found;
        end
    end

    // fully associative compare, first hit taken
    always_comb begin
        hit       = 1'b0;
        hit_entry = entry_q[0];
        hit_found = found_q[0];
        for (int i = 0; i < itlb_entries; i++) begin
            hit_vec[i] = valid_q[i] && (entry_q[i].vpn2 == vaddr[31:13]);
            if (hit_vec[i] && !hit) begin
                hit       = 1'b1;
                hit_entry = entry_q[i];
                hit_found = found_q[i];
            end
        end
    end

    // va bit 12 picks the even or odd half
    assign odd_page = vaddr[12];
    assign sel_pfn  = odd_page ? hit_entry.pfn1 : hit_entry.pfn0;
    assign sel_c    = odd_page ? hit_entry.c1 : hit_entry.c0;
    assign sel_v    = odd_page ? hit_entry.v1 : hit_entry.v0;

    always_comb begin
        xlate.ready  = 1'b0;
        xlate.paddr  = {3'b000, vaddr[28:0]};   // direct map for kseg0/1
        xlate.cached = 1'b0;
        xlate.exc    = fetch_pkg::exc_none;
        tlb_stall    = 1'b0;
        if (unmapped) begin
            xlate.ready  = 1'b1;
            xlate.cached = in_kseg0;   // kseg1 is uncached
        end else if (!hit) begin
            tlb_stall = 1'b1;          // wait for the main TLB
        end else if (!hit_found) begin
            xlate.ready = 1'b1;
            xlate.exc   = fetch_pkg::exc_tlb_refill;
        end else if (!sel_v) begin
            xlate.ready = 1'b1;
            xlate.exc   = fetch_pkg::exc_tlb_invalid;
        end else begin
            xlate.ready  = 1'b1;
            xlate.paddr  = {sel_pfn, vaddr[11:0]};
            xlate.cached = sel_c;
        end
    end

    assign miss_vpn2 = vaddr[31:13];   // only looked at while stalled

endmodule

//--- hw/fetch_request.sv
`timescale 1ns/1ps

module fetch_request (
    input  logic                  [31:0] pc,
    input  mmu_pkg::xlate_t       xlate,
    input  logic                  req_enable,
    input  logic                  reset,
    output fetch_pkg::fetch_req_t fetch_req,
    output fetch_pkg::fetch_exc_t fetch_exc
);

    logic misaligned;
    logic no_exc;

    assign misaligned = (pc[1:0] != 2'b00);

    // misalignment is seen before any TLB fault
    always_comb begin
        if (misaligned) begin
            fetch_exc = fetch_pkg::exc_addr_error;
        end else if (xlate.ready) begin
            fetch_exc = xlate.exc;
        end else begin
            fetch_exc = fetch_pkg::exc_none;   // still waiting on a fill
        end
    end

    assign no_exc = (fetch_exc == fetch_pkg::exc_none);

    // no request out of reset or while the translation is pending
    assign fetch_req.valid  = req_enable && xlate.ready && no_exc && !reset;
    assign fetch_req.paddr  = xlate.paddr;
    assign fetch_req.cached = xlate.cached;

endmodule

//--- hw/preif_stage.sv
`timescale 1ns/1ps

module preif_stage #(
    parameter logic [31:0] reset_vector = 32'hbfc0_0000,
    parameter int          itlb_entries = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pc_write,      // stage advance
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  fill_valid,    // one cycle answer from main tlb
    input  logic                  fill_found,
    input  mmu_pkg::page_entry_t  fill_entry,
    input  logic                  itlb_flush,
    input  logic                  req_enable,
    output logic [31:0]           pc,
    output fetch_pkg::fetch_req_t fetch_req,
    output fetch_pkg::fetch_exc_t fetch_exc,
    output logic                  tlb_stall,
    output logic [18:0]           miss_vpn2
);

    fetch_pkg::pc_src_t pc_src;
    mmu_pkg::xlate_t    xlate;

    redirect_arbiter u_redirect_arbiter (
        .redirect   (redirect),
        .pc_src     (pc_src)
    );

    pc_gen #(
        .reset_vector (reset_vector)
    ) u_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .pc_write   (pc_write),
        .pc_src     (pc_src),
        .redirect   (redirect),
        .pc         (pc)
    );

    // stall goes out as is, the pipeline decides about pc_write
    itlb_buffer #(
        .itlb_entries (itlb_entries)
    ) u_itlb_buffer (
        .clk        (clk),
        .reset      (reset),
        .vaddr      (pc),
        .flush      (itlb_flush),
        .fill_valid (fill_valid),
        .fill_found (fill_found),
        .fill_entry (fill_entry),
        .xlate      (xlate),
        .tlb_stall  (tlb_stall),
        .miss_vpn2  (miss_vpn2)
    );

    fetch_request u_fetch_request (
        .pc         (pc),
        .xlate      (xlate),
        .req_enable (req_enable),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_exc  (fetch_exc)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;   // first rising edge at half a period
    end

endmodule

//--- test/tb_preif.sv
`timescale 1ns/1ps

module tb_preif;

    localparam logic [31:0] reset_vector = 32'hbfc0_0000;   // kseg1
    localparam int          itlb_entries = 4;
    localparam int          clk_period   = 8;
    localparam int          max_cycles   = 400;   // all tests need well under this

    // model copy of one buffer slot
    typedef struct packed {
        logic                 found;
        mmu_pkg::page_entry_t entry;
    } model_entry_t;

    logic                  clk;
    logic                  reset;
    logic                  pc_write;
    fetch_pkg::redirect_t  redirect;
    logic                  fill_valid;
    logic                  fill_found;
    mmu_pkg::page_entry_t  fill_entry;
    logic                  itlb_flush;
    logic                  req_enable;
    logic [31:0]           pc;
    fetch_pkg::fetch_req_t fetch_req;
    fetch_pkg::fetch_exc_t fetch_exc;
    logic                  tlb_stall;
    logic [18:0]           miss_vpn2;

    logic [31:0]           model_pc;
    model_entry_t          model_tlb[$];   // oldest fill at the front
    logic [31:0]           exp_pc;
    logic                  exp_stall;
    logic [18:0]           exp_vpn2;
    fetch_pkg::fetch_exc_t exp_exc;
    logic                  exp_valid;
    logic [31:0]           exp_paddr;
    logic                  exp_cached;
    logic                  check_on;
    string                 test_name;
    int                    fail_count;

    tb_clock #(.period(clk_period)) clock_gen (.clk(clk));

    preif_stage #(
        .reset_vector (reset_vector),
        .itlb_entries (itlb_entries)
    ) preif_stage_i (
        .clk        (clk),
        .reset      (reset),
        .pc_write   (pc_write),
        .redirect   (redirect),
        .fill_valid (fill_valid),
        .fill_found (fill_found),
        .fill_entry (fill_entry),
        .itlb_flush (itlb_flush),
        .req_enable (req_enable),
        .pc         (pc),
        .fetch_req  (fetch_req),
        .fetch_exc  (fetch_exc),
        .tlb_stall  (tlb_stall),
        .miss_vpn2  (miss_vpn2)
    );

    task automatic fail_check(string what, logic [31:0] expected, logic [31:0] actual);
        fail_count++;
        $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
        $display("tests failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // DUT outputs seen just before each rising edge
    pc_check: assert property (@(posedge clk) disable iff (!check_on) pc == exp_pc)
        else fail_check("pc", exp_pc, $sampled(pc));
    reset_req_check: assert property (@(posedge clk) reset |-> !fetch_req.valid)
        else fail_check("valid in reset", 32'd0, 32'($sampled(fetch_req.valid)));
    stall_check: assert property (@(posedge clk) disable iff (!check_on)
        tlb_stall == exp_stall)
        else fail_check("tlb_stall", 32'(exp_stall), 32'($sampled(tlb_stall)));
    vpn2_check: assert property (@(posedge clk) disable iff (!check_on)
        exp_stall |-> miss_vpn2 == exp_vpn2)
        else fail_check("miss_vpn2", 32'(exp_vpn2), 32'($sampled(miss_vpn2)));
    exc_check: assert property (@(posedge clk) disable iff (!check_on) fetch_exc == exp_exc)
        else fail_check("fetch_exc", 32'(exp_exc), 32'($sampled(fetch_exc)));
    valid_check: assert property (@(posedge clk) disable iff (!check_on)
        fetch_req.valid == exp_valid)
        else fail_check("req valid", 32'(exp_valid), 32'($sampled(fetch_req.valid)));
    paddr_check: assert property (@(posedge clk) disable iff (!check_on)
        exp_valid |-> fetch_req.paddr == exp_paddr)
        else fail_check("paddr", exp_paddr, $sampled(fetch_req.paddr));
    cached_check: assert property (@(posedge clk) disable iff (!check_on)
        exp_valid |-> fetch_req.cached == exp_cached)
        else fail_check("cached", 32'(exp_cached), 32'($sampled(fetch_req.cached)));

    function automatic logic [31:0] expected_next_pc(fetch_pkg::redirect_t r,
                                                     logic [31:0] cur);
        if (r.eret_valid) return r.eret_pc;   // oldest source first
        if (r.exc_valid) return r.exc_vector;
        if (r.refetch_valid) return r.refetch_pc;
        if (r.correct_valid) return r.correct_pc;
        if (r.predict_valid) return r.predict_pc;
        return cur + 32'd4;
    endfunction

    function automatic void predict_outputs();
        logic         ready;
        int           hit_idx;
        model_entry_t e;
        ready      = 1'b0;
        hit_idx    = -1;
        exp_pc     = model_pc;
        exp_vpn2   = model_pc[31:13];
        exp_stall  = 1'b0;
        exp_exc    = fetch_pkg::exc_none;
        exp_paddr  = {3'b000, model_pc[28:0]};
        exp_cached = 1'b0;
        if (model_pc[31:29] == mmu_pkg::kseg0_base[31:29]) begin
            ready      = 1'b1;
            exp_cached = 1'b1;
        end else if (model_pc[31:29] == mmu_pkg::kseg1_base[31:29]) begin
            ready = 1'b1;
        end else begin
            for (int i = 0; i < model_tlb.size(); i++) begin
                if (hit_idx < 0 && model_tlb[i].entry.vpn2 == model_pc[31:13]) begin
                    hit_idx = i;
                end
            end
            if (hit_idx < 0) begin
                exp_stall = 1'b1;
            end else begin
                e     = model_tlb[hit_idx];
                ready = 1'b1;
                if (!e.found) begin
                    exp_exc = fetch_pkg::exc_tlb_refill;
                end else if (model_pc[12] ? !e.entry.v1 : !e.entry.v0) begin
                    exp_exc = fetch_pkg::exc_tlb_invalid;
                end else if (model_pc[12]) begin
                    exp_paddr  = {e.entry.pfn1, model_pc[11:0]};
                    exp_cached = e.entry.c1;
                end else begin
                    exp_paddr  = {e.entry.pfn0, model_pc[11:0]};
                    exp_cached = e.entry.c0;
                end
            end
        end
        if (model_pc[1:0] != 2'b00) begin
            exp_exc = fetch_pkg::exc_addr_error;   // beats any tlb fault
        end
        exp_valid = req_enable && ready && (exp_exc == fetch_pkg::exc_none) && !reset;
    endfunction

    // state after the edge, from the inputs that were applied at it
    function automatic void advance_model();
        if (reset) begin
            model_pc = reset_vector;
            model_tlb.delete();
        end else begin
            if (pc_write) begin
                model_pc = expected_next_pc(redirect, model_pc);
            end
            if (itlb_flush) begin
                model_tlb.delete();
            end else if (fill_valid) begin
                model_tlb.push_back({fill_found, fill_entry});
                if (model_tlb.size() > itlb_entries) begin
                    void'(model_tlb.pop_front());   // round robin drops the oldest
                end
            end
        end
    endfunction

    task automatic tick();
        predict_outputs();
        @(negedge clk);
        advance_model();
    endtask

    task automatic clear_inputs();
        redirect   = '0;
        fill_valid = 1'b0;
        fill_found = 1'b0;
        fill_entry = '0;
        itlb_flush = 1'b0;
    endtask

    task automatic jump_to(logic [31:0] addr);
        redirect            = '0;
        redirect.eret_valid = 1'b1;
        redirect.eret_pc    = addr;
        pc_write            = 1'b1;
        tick();
        redirect = '0;
        pc_write = 1'b0;
    endtask

    function automatic logic [31:0] random_addr();
        logic [31:0] a;
        a        = $urandom;
        a[31:29] = a[31] ? 3'b100 : 3'b101;   // kseg0 or kseg1
        a[1:0]   = 2'b00;
        return a;
    endfunction

    function automatic mmu_pkg::page_entry_t random_entry(logic [18:0] vpn2, logic v0,
                                                          logic v1);
        mmu_pkg::page_entry_t e;
        e.vpn2 = vpn2;
        e.pfn0 = 20'($urandom);
        e.pfn1 = 20'($urandom);
        e.c0   = 1'($urandom);
        e.c1   = 1'($urandom);
        e.v0   = v0;
        e.v1   = v1;
        return e;
    endfunction

    task automatic serve_miss(logic found, logic v0, logic v1);
        int waited;
        waited = 0;
        while (!tlb_stall && waited < 8) begin
            tick();
            waited++;
        end
        if (!tlb_stall) begin
            $display("tlb_stall never rose for mapped pc %h", model_pc);
            $display("tests failed");
            $fatal(1, "missing tlb stall");
        end
        tick();   // one stalled cycle
        fill_valid = 1'b1;
        fill_found = found;
        fill_entry = random_entry(model_pc[31:13], v0, v1);
        tick();
        fill_valid = 1'b0;
        fill_found = 1'b0;
    endtask

    initial begin
        #(max_cycles * clk_period + 100);
        $display("run timed out after %0d clock cycles", max_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] page;
        void'($urandom(32'h0e39_1e44));
        reset      = 1'b1;
        pc_write   = 1'b0;
        req_enable = 1'b1;
        check_on   = 1'b0;
        fail_count = 0;
        model_pc   = reset_vector;
        test_name  = "reset";
        clear_inputs();
        tick();
        check_on = 1'b1;   // pc is known after the first edge
        repeat (15) tick();
        reset = 1'b0;

        test_name = "sequential";
        pc_write  = 1'b1;
        repeat (10) tick();
        pc_write = 1'b0;
        repeat (4) tick();

        test_name = "redirect priority";
        for (int i = 0; i < 40; i++) begin
            redirect.eret_valid    = 1'($urandom % 4 == 0);
            redirect.exc_valid     = 1'($urandom % 4 == 0);
            redirect.refetch_valid = 1'($urandom % 4 == 0);
            redirect.correct_valid = 1'($urandom % 3 == 0);
            redirect.predict_valid = 1'($urandom % 2 == 0);
            redirect.eret_pc       = random_addr();
            redirect.exc_vector    = random_addr();
            redirect.refetch_pc    = random_addr();
            redirect.correct_pc    = random_addr();
            redirect.predict_pc    = random_addr();
            pc_write               = 1'($urandom % 4 != 0);
            tick();
        end
        redirect = '0;

        test_name = "unmapped";
        jump_to(32'ha000_4560);
        tick();
        jump_to(32'h8000_1230);
        tick();
        req_enable = 1'b0;   // no request without enable
        tick();
        req_enable = 1'b1;

        test_name = "mapped";
        jump_to(32'h0040_0000);
        serve_miss(1'b1, 1'b1, 1'b0);
        tick();
        jump_to(32'h0040_1000);   // odd half is invalid
        tick();
        test_name = "refill";
        jump_to(32'h1234_5000);
        serve_miss(1'b0, 1'b1, 1'b1);
        repeat (2) tick();
        test_name = "addr error over refill";
        jump_to(32'h1234_5006);   // same refill page, misalignment wins
        tick();

        test_name = "round robin";
        page = 32'h0;
        for (int i = 0; i < 5; i++) begin
            page = 32'h0100_0000 + 32'(i) * 32'h2000 + ($urandom & 32'h0000_1ffc);
            jump_to(page);
            serve_miss(1'b1, 1'($urandom), 1'($urandom));
            tick();
        end
        jump_to(32'h0100_0000);   // first page was pushed out
        tick();
        serve_miss(1'b1, 1'b1, 1'b1);
        tick();

        test_name = "addr error";
        jump_to(32'hbfc0_0102);
        tick();
        test_name = "flush";
        jump_to(page);
        tick();
        itlb_flush = 1'b1;
        tick();
        itlb_flush = 1'b0;
        serve_miss(1'b1, 1'b1, 1'b1);
        repeat (2) tick();

        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/fetch_pkg.sv
hw/mmu_pkg.sv
hw/redirect_arbiter.sv
hw/pc_gen.sv
hw/itlb_buffer.sv
hw/fetch_request.sv
hw/preif_stage.sv
test/tb_clock.sv
test/tb_preif.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_preif -f all.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_preif > sim.log 2>&1 \
    || echo "simulation exited with an error status" >> sim.log
cat sim.log

grep -q "tests failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAILED: no pass line in log"; exit 1; }
echo "PASSED"
